//--- soc_ifc_pkg.sv
// Shared definitions for the SoC interface register path.
// Holds the APB address map, the data widths, the decoded register
// select and the reset values used across the three stages and the watchdog.

`default_nettype none

package soc_ifc_pkg;

    localparam int apb_addr_w      = 8;
    localparam int fuse_uds_words  = 4;
    localparam int trng_data_words = 2;
    localparam int idx_w           = $clog2(fuse_uds_words);

    typedef logic [31:0]           data_t;
    typedef logic [apb_addr_w-1:0] addr_t;
    typedef logic [31:0]           user_t;
    typedef logic [idx_w-1:0]      idx_t;

    // Decoded register target
    typedef enum logic [3:0] {
        sel_fuse_uds,
        sel_fuse_wr_done,
        sel_fuse_pauser,
        sel_fuse_lock,
        sel_trng_pauser,
        sel_trng_lock,
        sel_trng_data,
        sel_wdt_en,
        sel_wdt_period,
        sel_wdt_restart,
        sel_wdt_status,
        sel_none
    } reg_sel_e;

    // Byte address map
    localparam addr_t addr_fuse_uds     = 8'h00;
    localparam addr_t addr_fuse_wr_done = 8'h10;
    localparam addr_t addr_fuse_pauser  = 8'h14;
    localparam addr_t addr_fuse_lock    = 8'h18;
    localparam addr_t addr_trng_pauser  = 8'h1C;
    localparam addr_t addr_trng_lock    = 8'h20;
    localparam addr_t addr_trng_data    = 8'h24;
    localparam addr_t addr_wdt_en       = 8'h30;
    localparam addr_t addr_wdt_period   = 8'h34;
    localparam addr_t addr_wdt_restart  = 8'h38;
    localparam addr_t addr_wdt_status   = 8'h3C;

    localparam user_t def_valid_pauser = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

//--- apb_req_stage.sv
// First pipeline stage of the SoC register path.
// Captures an APB transfer in its setup cycle and hands it on as a
// one-cycle request, then returns the stage-3 response to the bus.

`default_nettype none

module apb_req_stage
    import soc_ifc_pkg::*;
(
    input  logic  clk,
    input  logic  cptra_rst_b,

    // APB slave side
    input  addr_t paddr_i,
    input  logic  psel_i,
    input  logic  penable_i,
    input  logic  pwrite_i,
    input  data_t pwdata_i,
    input  user_t pauser_i,
    output logic  pready_o,
    output data_t prdata_o,
    output logic  pslverr_o,

    // Response from the execution stage
    input  logic  rsp_valid_i,
    input  data_t rsp_rdata_i,
    input  logic  rsp_err_i,

    // Request to the access check stage
    output logic  req_valid_o,
    output logic  req_write_o,
    output addr_t req_addr_o,
    output data_t req_wdata_o,
    output user_t req_user_o
);

    logic setup_phase;

    // Setup cycle is the only one with psel high and penable low
    assign setup_phase = psel_i & ~penable_i;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= setup_phase;
        end
    end

    // Transfer payload
    always_ff @(posedge clk) begin
        if (setup_phase) begin
            req_write_o <= pwrite_i;
            req_addr_o  <= paddr_i;
            req_wdata_o <= pwdata_i;
            req_user_o  <= pauser_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response path
    // pready stays low until stage 3 answers, which holds the SoC in access
    ////////////////////////////////////////////////////////////////////////////
    assign pready_o  = rsp_valid_i;
    assign prdata_o  = rsp_valid_i ? rsp_rdata_i : '0;
    assign pslverr_o = rsp_valid_i & rsp_err_i;

endmodule

`default_nettype wire

//--- access_check_stage.sv
// Second pipeline stage of the SoC register path.
// Decodes the request address and applies the fuse, lock and TRNG
// PAUSER rules. The verdict is registered and executed as-is by stage 3.

`default_nettype none

module access_check_stage
    import soc_ifc_pkg::*;
(
    input  logic     clk,
    input  logic     cptra_rst_b,

    // Request from the capture stage
    input  logic     req_valid_i,
    input  logic     req_write_i,
    input  addr_t    req_addr_i,
    input  data_t    req_wdata_i,
    input  user_t    req_user_i,

    // Lock state held in the register bank
    input  logic     fuse_wr_done_i,
    input  logic     fuse_lock_i,
    input  user_t    fuse_pauser_i,
    input  logic     trng_lock_i,
    input  user_t    trng_pauser_i,

    // Checked request to the execution stage
    output logic     exe_valid_o,
    output reg_sel_e exe_sel_o,
    output idx_t     exe_index_o,
    output logic     exe_write_o,
    output data_t    exe_wdata_o,
    output logic     exe_wr_allow_o,
    output logic     exe_rd_mask_o,
    output logic     exe_err_o
);

    reg_sel_e dec_sel;
    idx_t     dec_index;
    addr_t    uds_off;
    addr_t    trng_off;
    logic     fuse_user_ok;
    logic     trng_user_ok;
    logic     wr_allow;

    assign uds_off  = req_addr_i - addr_fuse_uds;
    assign trng_off = req_addr_i - addr_trng_data;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        dec_sel   = sel_none;
        dec_index = '0;
        if (req_addr_i[1:0] == 2'b00) begin
            if (req_addr_i < addr_fuse_uds + addr_t'(4 * fuse_uds_words)) begin
                dec_sel   = sel_fuse_uds;
                dec_index = uds_off[idx_w+1:2];
            end else if (req_addr_i >= addr_trng_data &&
                         req_addr_i < addr_trng_data + addr_t'(4 * trng_data_words)) begin
                dec_sel   = sel_trng_data;
                dec_index = trng_off[idx_w+1:2];
            end else begin
                case (req_addr_i)
                    addr_fuse_wr_done: dec_sel = sel_fuse_wr_done;
                    addr_fuse_pauser:  dec_sel = sel_fuse_pauser;
                    addr_fuse_lock:    dec_sel = sel_fuse_lock;
                    addr_trng_pauser:  dec_sel = sel_trng_pauser;
                    addr_trng_lock:    dec_sel = sel_trng_lock;
                    addr_wdt_en:       dec_sel = sel_wdt_en;
                    addr_wdt_period:   dec_sel = sel_wdt_period;
                    addr_wdt_restart:  dec_sel = sel_wdt_restart;
                    addr_wdt_status:   dec_sel = sel_wdt_status;
                    default:           dec_sel = sel_none;
                endcase
            end
        end
    end

    // An unlocked PAUSER register admits every requester
    assign fuse_user_ok = ~fuse_lock_i | (req_user_i == fuse_pauser_i);
    assign trng_user_ok = ~trng_lock_i | (req_user_i == trng_pauser_i);

    always_comb begin
        case (dec_sel)
            sel_fuse_uds:     wr_allow = ~fuse_wr_done_i & fuse_user_ok;
            sel_fuse_wr_done: wr_allow = ~fuse_wr_done_i;
            sel_fuse_pauser,
            sel_fuse_lock:    wr_allow = ~fuse_lock_i;
            sel_trng_pauser,
            sel_trng_lock:    wr_allow = ~trng_lock_i;
            sel_trng_data:    wr_allow = trng_user_ok;
            sel_none:         wr_allow = 1'b0;
            default:          wr_allow = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            exe_sel_o      <= dec_sel;
            exe_index_o    <= dec_index;
            exe_write_o    <= req_write_i;
            exe_wdata_o    <= req_wdata_i;
            exe_wr_allow_o <= wr_allow;
            exe_rd_mask_o  <= (dec_sel == sel_trng_data) & ~trng_user_ok;
            exe_err_o      <= (dec_sel == sel_none);
        end
    end

endmodule

`default_nettype wire

//--- fuse_trng_regs.sv
// Third pipeline stage of the SoC register path.
// Holds the fuse, PAUSER lock, TRNG and watchdog control registers,
// applies a write already cleared by stage 2 and returns the read data.

`default_nettype none

module fuse_trng_regs
    import soc_ifc_pkg::*;
(
    input  logic                         clk,
    input  logic                         cptra_rst_b,

    // Checked request from the access check stage
    input  logic                         exe_valid_i,
    input  reg_sel_e                     exe_sel_i,
    input  idx_t                         exe_index_i,
    input  logic                         exe_write_i,
    input  data_t                        exe_wdata_i,
    input  logic                         exe_wr_allow_i,
    input  logic                         exe_rd_mask_i,
    input  logic                         exe_err_i,
    input  logic                         wdt_timeout_i,

    // Response to the capture stage
    output logic                         rsp_valid_o,
    output data_t                        rsp_rdata_o,
    output logic                         rsp_err_o,

    // Lock state for the access check
    output logic                         fuse_wr_done_o,
    output logic                         fuse_lock_o,
    output user_t                        fuse_pauser_o,
    output logic                         trng_lock_o,
    output user_t                        trng_pauser_o,

    output data_t [fuse_uds_words-1:0]   fuse_uds_o,
    output data_t [trng_data_words-1:0]  trng_data_o,

    // Watchdog control
    output logic                         wdt_en_o,
    output data_t                        wdt_period_o,
    output logic                         wdt_restart_o,
    output logic                         wdt_status_clr_o
);

    logic  wr_en;
    data_t rd_word;

    assign wr_en = exe_valid_i & exe_write_i & exe_wr_allow_i;

    ////////////////////////////////////////////////////////////////////////////
    // Register bank
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_uds_o     <= '0;
            fuse_wr_done_o <= 1'b0;
            fuse_pauser_o  <= def_valid_pauser;
            fuse_lock_o    <= 1'b0;
            trng_pauser_o  <= def_valid_pauser;
            trng_lock_o    <= 1'b0;
            trng_data_o    <= '0;
            wdt_en_o       <= 1'b0;
            wdt_period_o   <= '0;
        end else if (wr_en) begin
            case (exe_sel_i)
                sel_fuse_uds:     fuse_uds_o[exe_index_i] <= exe_wdata_i;
                sel_fuse_wr_done: fuse_wr_done_o <= exe_wdata_i[0];
                sel_fuse_pauser:  fuse_pauser_o <= exe_wdata_i;
                sel_fuse_lock:    fuse_lock_o <= exe_wdata_i[0];
                sel_trng_pauser:  trng_pauser_o <= exe_wdata_i;
                sel_trng_lock:    trng_lock_o <= exe_wdata_i[0];
                sel_trng_data:    trng_data_o[exe_index_i[0]] <= exe_wdata_i;
                sel_wdt_en:       wdt_en_o <= exe_wdata_i[0];
                sel_wdt_period:   wdt_period_o <= exe_wdata_i;
                default: ;
            endcase
        end
    end

    // Restart and status clear act once per write
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wdt_restart_o    <= 1'b0;
            wdt_status_clr_o <= 1'b0;
        end else begin
            wdt_restart_o    <= wr_en & (exe_sel_i == sel_wdt_restart);
            wdt_status_clr_o <= wr_en & (exe_sel_i == sel_wdt_status) & exe_wdata_i[0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (exe_sel_i)
            sel_fuse_uds:     rd_word = fuse_uds_o[exe_index_i];
            sel_fuse_wr_done: rd_word = {31'b0, fuse_wr_done_o};
            sel_fuse_pauser:  rd_word = fuse_pauser_o;
            sel_fuse_lock:    rd_word = {31'b0, fuse_lock_o};
            sel_trng_pauser:  rd_word = trng_pauser_o;
            sel_trng_lock:    rd_word = {31'b0, trng_lock_o};
            sel_trng_data:    rd_word = trng_data_o[exe_index_i[0]];
            sel_wdt_en:       rd_word = {31'b0, wdt_en_o};
            sel_wdt_period:   rd_word = wdt_period_o;
            sel_wdt_status:   rd_word = {31'b0, wdt_timeout_i};
            default:          rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= exe_valid_i;
        end
    end

    // Foreign requester sees zero on locked TRNG data
    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            rsp_rdata_o <= (exe_write_i || exe_rd_mask_i) ? '0 : rd_word;
            rsp_err_o   <= exe_err_i;
        end
    end

endmodule

`default_nettype wire

//--- wdt_timer.sv
// Single watchdog timer beside the register bank.
// Counts while enabled and raises a sticky timeout that software clears
// through the status register. The timeout also drives the error interrupt.

`default_nettype none

module wdt_timer
    import soc_ifc_pkg::*;
(
    input  logic  clk,
    input  logic  cptra_rst_b,
    input  logic  wdt_en_i,
    input  data_t wdt_period_i,
    input  logic  wdt_restart_i,
    input  logic  wdt_status_clr_i,
    output logic  wdt_timeout_o,
    output logic  wdt_error_intr_o
);

    data_t count;
    logic  expired;

    assign expired = wdt_en_i & ~wdt_restart_i & (count >= wdt_period_i);

    // Count holds at zero while a timeout is pending
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            count <= '0;
        end else if (!wdt_en_i || wdt_restart_i || wdt_timeout_o) begin
            count <= '0;
        end else if (count != '1) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wdt_timeout_o <= 1'b0;
        end else if (wdt_status_clr_i) begin
            wdt_timeout_o <= 1'b0;
        end else if (expired) begin
            wdt_timeout_o <= 1'b1;
        end
    end

    assign wdt_error_intr_o = wdt_timeout_o;

endmodule

`default_nettype wire

//--- soc_ifc_top.sv
// Top level of the SoC interface register path.
// Chains capture, access check and execution stages behind the APB port
// and places the watchdog timer next to the register bank.

`default_nettype none

module soc_ifc_top
    import soc_ifc_pkg::*;
(
    input  logic                         clk,
    input  logic                         cptra_rst_b,

    // SoC APB port
    input  addr_t                        paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  data_t                        pwdata_i,
    input  user_t                        pauser_i,
    output logic                         pready_o,
    output data_t                        prdata_o,
    output logic                         pslverr_o,

    output data_t [fuse_uds_words-1:0]   fuse_uds_o,
    output data_t [trng_data_words-1:0]  trng_data_o,
    output logic                         wdt_timeout_o,
    output logic                         wdt_error_intr_o
);

    // Stage 1 to stage 2
    logic     req_valid;
    logic     req_write;
    addr_t    req_addr;
    data_t    req_wdata;
    user_t    req_user;

    // Stage 2 to stage 3
    logic     exe_valid;
    reg_sel_e exe_sel;
    idx_t     exe_index;
    logic     exe_write;
    data_t    exe_wdata;
    logic     exe_wr_allow;
    logic     exe_rd_mask;
    logic     exe_err;

    // Stage 3 back to stage 1 and 2
    logic     rsp_valid;
    data_t    rsp_rdata;
    logic     rsp_err;
    logic     fuse_wr_done;
    logic     fuse_lock;
    user_t    fuse_pauser;
    logic     trng_lock;
    user_t    trng_pauser;

    // Watchdog control
    logic     wdt_en;
    data_t    wdt_period;
    logic     wdt_restart;
    logic     wdt_status_clr;

    apb_req_stage i_apb_req_stage (
        .clk         (clk),
        .cptra_rst_b (cptra_rst_b),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .pauser_i    (pauser_i),
        .pready_o    (pready_o),
        .prdata_o    (prdata_o),
        .pslverr_o   (pslverr_o),
        .rsp_valid_i (rsp_valid),
        .rsp_rdata_i (rsp_rdata),
        .rsp_err_i   (rsp_err),
        .req_valid_o (req_valid),
        .req_write_o (req_write),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .req_user_o  (req_user)
    );

    access_check_stage i_access_check_stage (
        .clk            (clk),
        .cptra_rst_b    (cptra_rst_b),
        .req_valid_i    (req_valid),
        .req_write_i    (req_write),
        .req_addr_i     (req_addr),
        .req_wdata_i    (req_wdata),
        .req_user_i     (req_user),
        .fuse_wr_done_i (fuse_wr_done),
        .fuse_lock_i    (fuse_lock),
        .fuse_pauser_i  (fuse_pauser),
        .trng_lock_i    (trng_lock),
        .trng_pauser_i  (trng_pauser),
        .exe_valid_o    (exe_valid),
        .exe_sel_o      (exe_sel),
        .exe_index_o    (exe_index),
        .exe_write_o    (exe_write),
        .exe_wdata_o    (exe_wdata),
        .exe_wr_allow_o (exe_wr_allow),
        .exe_rd_mask_o  (exe_rd_mask),
        .exe_err_o      (exe_err)
    );

    fuse_trng_regs i_fuse_trng_regs (
        .clk              (clk),
        .cptra_rst_b      (cptra_rst_b),
        .exe_valid_i      (exe_valid),
        .exe_sel_i        (exe_sel),
        .exe_index_i      (exe_index),
        .exe_write_i      (exe_write),
        .exe_wdata_i      (exe_wdata),
        .exe_wr_allow_i   (exe_wr_allow),
        .exe_rd_mask_i    (exe_rd_mask),
        .exe_err_i        (exe_err),
        .wdt_timeout_i    (wdt_timeout_o),
        .rsp_valid_o      (rsp_valid),
        .rsp_rdata_o      (rsp_rdata),
        .rsp_err_o        (rsp_err),
        .fuse_wr_done_o   (fuse_wr_done),
        .fuse_lock_o      (fuse_lock),
        .fuse_pauser_o    (fuse_pauser),
        .trng_lock_o      (trng_lock),
        .trng_pauser_o    (trng_pauser),
        .fuse_uds_o       (fuse_uds_o),
        .trng_data_o      (trng_data_o),
        .wdt_en_o         (wdt_en),
        .wdt_period_o     (wdt_period),
        .wdt_restart_o    (wdt_restart),
        .wdt_status_clr_o (wdt_status_clr)
    );

    wdt_timer i_wdt_timer (
        .clk              (clk),
        .cptra_rst_b      (cptra_rst_b),
        .wdt_en_i         (wdt_en),
        .wdt_period_i     (wdt_period),
        .wdt_restart_i    (wdt_restart),
        .wdt_status_clr_i (wdt_status_clr),
        .wdt_timeout_o    (wdt_timeout_o),
        .wdt_error_intr_o (wdt_error_intr_o)
    );

endmodule

`default_nettype wire

//--- soc_ifc_tb.sv
// Directed testbench for the SoC interface register path.
// Drives APB transfers into soc_ifc_top, checks the fuse, TRNG and
// watchdog rules against expected values, and prints a summary at the end.

`default_nettype none

module soc_ifc_tb
    import soc_ifc_pkg::*;
();

    logic                         clk = 1'b0;
    logic                         cptra_rst_b;
    addr_t                        paddr_i;
    logic                         psel_i;
    logic                         penable_i;
    logic                         pwrite_i;
    data_t                        pwdata_i;
    user_t                        pauser_i;
    logic                         pready_o;
    data_t                        prdata_o;
    logic                         pslverr_o;
    data_t [fuse_uds_words-1:0]   fuse_uds;
    data_t [trng_data_words-1:0]  trng_data;
    logic                         wdt_timeout_o;
    logic                         wdt_error_intr_o;

    string       cur_test;
    int          test_errs = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int unsigned seed_ret;
    data_t       uds_exp [fuse_uds_words];
    logic        intr_watch = 1'b0;
    int          intr_high = 0;

    soc_ifc_top dut (
        .clk              (clk),
        .cptra_rst_b      (cptra_rst_b),
        .paddr_i          (paddr_i),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .pwdata_i         (pwdata_i),
        .pauser_i         (pauser_i),
        .pready_o         (pready_o),
        .prdata_o         (prdata_o),
        .pslverr_o        (pslverr_o),
        .fuse_uds_o       (fuse_uds),
        .trng_data_o      (trng_data),
        .wdt_timeout_o    (wdt_timeout_o),
        .wdt_error_intr_o (wdt_error_intr_o)
    );

    always #5 clk = ~clk;

    // Counts interrupt samples while the restart window is open
    always @(negedge clk) begin
        if (!intr_watch) begin
            intr_high <= 0;
        end else if (wdt_error_intr_o) begin
            intr_high <= intr_high + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Check and report helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string what, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("Error: %s %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS %s", cur_test);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB master
    // Called a little after a rising edge, returns the same way
    ////////////////////////////////////////////////////////////////////////////
    task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                                input user_t user, output data_t rdata, output logic slverr);
        int cycles;
        paddr_i   = addr;
        pwrite_i  = write;
        pwdata_i  = wdata;
        pauser_i  = user;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(posedge clk);
        #1;
        penable_i = 1'b1;
        cycles = 0;
        while (!pready_o && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!pready_o) begin
            $display("Error: %s got no pready_o within 10 access cycles", cur_test);
            test_errs++;
        end else begin
            // pready belongs in the third access cycle
            check_value("pready access cycle", 32'd3, cycles);
        end
        rdata  = prdata_o;
        slverr = pslverr_o;
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t data, input user_t user);
        data_t rdata;
        logic  slverr;
        apb_transfer(1'b1, addr, data, user, rdata, slverr);
        // Refused writes are silent
        check_value("pslverr on write", 32'd0, {31'b0, slverr});
    endtask

    task automatic apb_read(input addr_t addr, input user_t user,
                            output data_t data, output logic slverr);
        apb_transfer(1'b0, addr, 32'h0, user, data, slverr);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_and_timing();
        data_t rdata;
        logic  err;
        cur_test = "reset_and_timing";
        check_value("pready after reset", 32'd0, {31'b0, pready_o});
        check_value("pslverr after reset", 32'd0, {31'b0, pslverr_o});
        check_value("interrupt after reset", 32'd0, {31'b0, wdt_error_intr_o});
        apb_read(8'h2C, 32'h0, rdata, err);
        check_value("unmapped rdata", 32'h0, rdata);
        check_value("unmapped pslverr", 32'd1, {31'b0, err});
        finish_test();
    endtask

    task automatic fuse_pauser_lock();
        data_t rdata;
        logic  err;
        cur_test = "fuse_pauser_lock";
        apb_write(addr_fuse_pauser, 32'h0000_1234, 32'h0);
        apb_write(addr_fuse_lock, 32'h1, 32'h0);
        apb_write(addr_fuse_uds, 32'hDEAD_0001, 32'h0000_5678);
        check_value("uds0 after foreign write", 32'h0, fuse_uds[0]);
        apb_write(addr_fuse_uds, 32'h0BAD_F00D, 32'h0000_1234);
        check_value("uds0 after valid write", 32'h0BAD_F00D, fuse_uds[0]);
        apb_read(addr_fuse_uds, 32'h0000_5678, rdata, err);
        check_value("uds0 read", 32'h0BAD_F00D, rdata);
        // Once locked neither the PAUSER nor the lock may move
        apb_write(addr_fuse_pauser, 32'h0000_9999, 32'h0000_1234);
        apb_write(addr_fuse_lock, 32'h0, 32'h0000_1234);
        apb_read(addr_fuse_pauser, 32'h0, rdata, err);
        check_value("fuse_pauser after lock", 32'h0000_1234, rdata);
        apb_read(addr_fuse_lock, 32'h0, rdata, err);
        check_value("fuse_lock after lock", 32'h1, rdata);
        finish_test();
    endtask

    task automatic fuse_stickiness();
        data_t rdata;
        logic  err;
        cur_test = "fuse_stickiness";
        for (int i = 0; i < fuse_uds_words; i++) begin
            uds_exp[i] = $urandom;
            apb_write(addr_fuse_uds + addr_t'(4 * i), uds_exp[i], 32'h0000_1234);
        end
        for (int i = 0; i < fuse_uds_words; i++) begin
            apb_read(addr_fuse_uds + addr_t'(4 * i), 32'h0, rdata, err);
            check_value("uds read", uds_exp[i], rdata);
            check_value("fuse_uds_o", uds_exp[i], fuse_uds[i]);
        end
        apb_write(addr_fuse_wr_done, 32'h1, 32'h0);
        for (int i = 0; i < fuse_uds_words; i++) begin
            apb_write(addr_fuse_uds + addr_t'(4 * i), ~uds_exp[i], 32'h0000_1234);
            apb_read(addr_fuse_uds + addr_t'(4 * i), 32'h0, rdata, err);
            check_value("uds after wr_done", uds_exp[i], rdata);
        end
        apb_write(addr_fuse_wr_done, 32'h0, 32'h0);
        apb_read(addr_fuse_wr_done, 32'h0, rdata, err);
        check_value("fuse_wr_done", 32'h1, rdata);
        finish_test();
    endtask

    task automatic trng_filtering();
        data_t rdata;
        logic  err;
        cur_test = "trng_filtering";
        apb_write(addr_trng_pauser, 32'h0000_AAAA, 32'h0);
        apb_write(addr_trng_lock, 32'h1, 32'h0);
        apb_write(addr_trng_data, 32'h5A5A_1234, 32'h0000_AAAA);
        check_value("trng_data_o after valid write", 32'h5A5A_1234, trng_data[0]);
        apb_write(addr_trng_data + addr_t'(4), 32'hC3C3_0001, 32'h0000_AAAA);
        check_value("trng_data_o word 1", 32'hC3C3_0001, trng_data[1]);
        check_value("trng_data_o word 0 kept", 32'h5A5A_1234, trng_data[0]);
        apb_write(addr_trng_data, 32'h0F0F_0F0F, 32'h0000_BBBB);
        check_value("trng_data_o after foreign write", 32'h5A5A_1234, trng_data[0]);
        apb_read(addr_trng_data, 32'h0000_BBBB, rdata, err);
        check_value("foreign read", 32'h0, rdata);
        apb_read(addr_trng_data, 32'h0000_AAAA, rdata, err);
        check_value("valid read", 32'h5A5A_1234, rdata);
        finish_test();
    endtask

    task automatic watchdog_timeout();
        data_t rdata;
        logic  err;
        int    elapsed;
        cur_test = "watchdog_timeout";
        apb_write(addr_wdt_period, 32'd20, 32'h0);
        apb_write(addr_wdt_en, 32'h1, 32'h0);
        // Enable landed one cycle before the write returned
        elapsed = 1;
        while (!wdt_timeout_o && elapsed < 30) begin
            @(posedge clk);
            #1;
            elapsed++;
        end
        if (!wdt_timeout_o) begin
            $display("Error: %s timeout did not rise within 30 cycles", cur_test);
            test_errs++;
        end else if (elapsed < 20) begin
            $display("Error: %s timeout cycle expected 20 to 30 actual %0d", cur_test, elapsed);
            test_errs++;
        end
        check_value("interrupt on timeout", 32'd1, {31'b0, wdt_error_intr_o});
        @(posedge clk);
        #1;
        apb_read(addr_wdt_status, 32'h0, rdata, err);
        check_value("status bit 0", 32'h1, rdata & 32'h1);
        apb_write(addr_wdt_status, 32'h1, 32'h0);
        check_value("interrupt after clear", 32'd0, {31'b0, wdt_error_intr_o});
        intr_watch = 1'b1;
        repeat (6) begin
            apb_write(addr_wdt_restart, 32'h1, 32'h0);
            repeat (6) @(posedge clk);
            #1;
        end
        intr_watch = 1'b0;
        check_value("interrupt samples during restarts", 32'd0, intr_high);
        finish_test();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and run limit
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        seed_ret    = $urandom(88921);
        cptra_rst_b = 1'b0;
        paddr_i     = '0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        pwdata_i    = '0;
        pauser_i    = '0;
        repeat (5) @(posedge clk);
        #1;
        cptra_rst_b = 1'b1;
        reset_and_timing();
        fuse_pauser_lock();
        fuse_stickiness();
        trng_filtering();
        watchdog_timeout();
        $display("Tests passed: %0d  failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Roughly 40 transfers plus the timer runs fit well inside this bound
    initial begin
        #20000;
        $display("Run exceeded its time limit before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
soc_ifc_pkg.sv
apb_req_stage.sv
access_check_stage.sv
fuse_trng_regs.sv
wdt_timer.sv
soc_ifc_top.sv
soc_ifc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the SoC interface testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module soc_ifc_tb -o soc_ifc_sim
./obj_dir/soc_ifc_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
